/* hw/cpu6502Pkg.sv */
`default_nettype none

// instruction set view of the 6502, shared by decode and its checkers
package cpu6502Pkg;

    // official mnemonics; the accumulator shifts get their own codes
    typedef enum logic [5:0] {
        NONE,               // illegal or unassigned slot
        ADC, AND, ASL, BCC,
        BCS, BEQ, BIT, BMI,
        BNE, BPL, BRK, BVC,
        BVS, CLC, CLD, CLI,
        CLV, CMP, CPX, CPY,
        DEC, DEX, DEY, EOR,
        INC, INX, INY, JMP,
        JSR, LDA, LDX, LDY,
        LSR, NOP, ORA, PHA,
        PHP, PLA, PLP, ROL,
        ROR, RTI, RTS, SBC,
        SEC, SED, SEI, STA,
        STX, STY, TAX, TAY,
        TSX, TXA, TXS, TYA,
        ASLA, ROLA, LSRA, RORA  // accumulator forms
    } mnemonicT;

    typedef enum logic [3:0] {
        ACC,    // accumulator
        IMPL,   // implied
        IMM,    // #nn
        ZPG,
        ZPGX,
        ZPGY,
        ABS,
        ABSX,
        ABSY,
        IND,    // jmp (nnnn) only
        XIND,   // (zp,x)
        INDY,   // (zp),y
        REL     // branches
    } addrModeT;

endpackage

`default_nettype wire

/* hw/decodePkg.sv */
`default_nettype none

`include "decoder_cfg.svh"

// records handed from stage to stage in the decode front end
package decodePkg;

    import cpu6502Pkg::*;

    typedef struct packed {
        mnemonicT   mnemonic;
        addrModeT   mode;
        logic [1:0] count;      // operand bytes after the opcode
        logic       illegal;
    } opInfoT;

    typedef struct packed {
        logic [15:0]         pc;        // address of the opcode byte
        logic [`BYTE_W-1:0]  opcode;
        opInfoT              info;
        logic [`BYTE_W-1:0]  opLow;
        logic [`BYTE_W-1:0]  opHigh;
    } rawInstrT;

    typedef struct packed {
        logic [15:0]         pc;
        logic [`BYTE_W-1:0]  opcode;
        opInfoT              info;
        logic [15:0]         operand;   // little-endian join, zero-extended
        logic [15:0]         target;    // branch destination, rel only
    } instrT;

endpackage

`default_nettype wire

/* hw/decodeTop.sv */
`default_nettype none
`timescale 1ns/100ps

`include "decoder_cfg.svh"

// byte stream in, one resolved record out two cycles after the last byte
module decodeTop import decodePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               byteValid,
    input  logic [`BYTE_W-1:0] byteData,
    input  logic               pcLoad,
    input  logic [15:0]        pcLoadValue,
    output logic               instrValid,
    output instrT              instr
);

    logic     rawValid;
    rawInstrT raw;

    instrAssembler u_assembler (
        .clk         (clk),
        .arstN       (arstN),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .pcLoad      (pcLoad),
        .pcLoadValue (pcLoadValue),
        .rawValid    (rawValid),
        .raw         (raw)
    );

    operandResolver u_resolver (
        .clk        (clk),
        .arstN      (arstN),
        .rawValid   (rawValid),
        .raw        (raw),
        .instrValid (instrValid),
        .instr      (instr)
    );

endmodule

`default_nettype wire

/* hw/decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// program counter after reset
`define RESET_PC 16'h0200

// width of one byte on the fetch stream
`define BYTE_W 8

`endif

/* hw/instrAssembler.sv */
`default_nettype none
`timescale 1ns/100ps

`include "decoder_cfg.svh"

module instrAssembler import decodePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               byteValid,
    input  logic [`BYTE_W-1:0] byteData,
    input  logic               pcLoad,
    input  logic [15:0]        pcLoadValue,
    output logic               rawValid,
    output rawInstrT           raw
);

    // which byte of the instruction comes next
    typedef enum logic [1:0] {
        expOpcode = 2'd0,
        expLow    = 2'd1,
        expHigh   = 2'd2
    } expectT;

    expectT      state;
    expectT      curState;
    logic [15:0] pc;
    logic [15:0] curPc;
    opInfoT      decInfo;
    rawInstrT    rec;       // record under construction
    rawInstrT    nextRec;
    logic        done;

    opcodeDecoder u_decoder (
        .opcode (byteData),
        .info   (decInfo)
    );

    // a load takes effect for a byte in the same cycle
    assign curPc    = pcLoad ? pcLoadValue : pc;
    assign curState = pcLoad ? expOpcode : state;

    always_comb begin
        nextRec = rec;
        done    = 1'b0;
        case (curState)
            expOpcode: begin
                nextRec.pc     = curPc;
                nextRec.opcode = byteData;
                nextRec.info   = decInfo;
                nextRec.opLow  = '0;
                nextRec.opHigh = '0;
                done           = (decInfo.count == 2'd0);
            end
            expLow: begin
                nextRec.opLow = byteData;
                done          = (rec.info.count == 2'd1);
            end
            default: begin
                nextRec.opHigh = byteData;
                done           = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc       <= `RESET_PC;
            state    <= expOpcode;
            rawValid <= 1'b0;
        end else begin
            rawValid <= byteValid && done;
            if (byteValid) begin
                pc <= curPc + 16'd1;
                if (done) state <= expOpcode;
                else if (curState == expOpcode) state <= expLow;
                else state <= expHigh;
            end else if (pcLoad) begin
                pc    <= pcLoadValue;
                state <= expOpcode;   // partial record is dropped
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byteValid) rec <= nextRec;
    end

    // rec holds still until the next byte is taken
    assign raw = rec;

    assert property (@(posedge clk) disable iff (!arstN)
        (state != expOpcode) |-> (2'(state) <= rec.info.count));

    assert property (@(posedge clk) disable iff (!arstN)
        rawValid ##1 !byteValid |=> !rawValid);

endmodule

`default_nettype wire

/* hw/opcodeDecoder.sv */
`default_nettype none
`timescale 1ns/100ps

`include "decoder_cfg.svh"

module opcodeDecoder import cpu6502Pkg::*, decodePkg::*; (
    input  logic [`BYTE_W-1:0] opcode,
    output opInfoT             info
);

    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;

    mnemonicT   mn;
    mnemonicT   rmwMn;  // shared column of the cc=10 group
    addrModeT   am;
    logic [1:0] len;

    assign aaa = opcode[7:5];
    assign bbb = opcode[4:2];
    assign cc  = opcode[1:0];

    always_comb begin
        case (aaa)
            3'b000:  rmwMn = ASL;
            3'b001:  rmwMn = ROL;
            3'b010:  rmwMn = LSR;
            3'b011:  rmwMn = ROR;
            3'b100:  rmwMn = STX;
            3'b101:  rmwMn = LDX;
            3'b110:  rmwMn = DEC;
            default: rmwMn = INC;
        endcase
    end

    always_comb begin : tableWalk
        mn = NONE;
        am = IMPL;
        case (cc)
            2'b00: begin
                case (bbb)
                    3'b000: begin
                        case (aaa)
                            3'b000:  mn = BRK;  // signature byte ignored
                            3'b001:  mn = JSR;
                            3'b010:  mn = RTI;
                            3'b011:  mn = RTS;
                            3'b101:  mn = LDY;
                            3'b110:  mn = CPY;
                            3'b111:  mn = CPX;
                            default: mn = NONE;
                        endcase
                        if (aaa == 3'b001) am = ABS;
                        else if (aaa[2]) am = IMM;
                    end
                    3'b001: begin
                        am = ZPG;
                        case (aaa)
                            3'b001:  mn = BIT;
                            3'b100:  mn = STY;
                            3'b101:  mn = LDY;
                            3'b110:  mn = CPY;
                            3'b111:  mn = CPX;
                            default: mn = NONE;
                        endcase
                    end
                    3'b010: begin
                        case (aaa)
                            3'b000:  mn = PHP;
                            3'b001:  mn = PLP;
                            3'b010:  mn = PHA;
                            3'b011:  mn = PLA;
                            3'b100:  mn = DEY;
                            3'b101:  mn = TAY;
                            3'b110:  mn = INY;
                            default: mn = INX;
                        endcase
                    end
                    3'b011: begin
                        am = ABS;
                        case (aaa)
                            3'b001: mn = BIT;
                            3'b010: mn = JMP;
                            3'b011: begin
                                mn = JMP;
                                am = IND;   // 6C, the only indirect opcode
                            end
                            3'b100:  mn = STY;
                            3'b101:  mn = LDY;
                            3'b110:  mn = CPY;
                            3'b111:  mn = CPX;
                            default: mn = NONE;
                        endcase
                    end
                    3'b100: begin
                        am = REL;
                        case (aaa)
                            3'b000:  mn = BPL;
                            3'b001:  mn = BMI;
                            3'b010:  mn = BVC;
                            3'b011:  mn = BVS;
                            3'b100:  mn = BCC;
                            3'b101:  mn = BCS;
                            3'b110:  mn = BNE;
                            default: mn = BEQ;
                        endcase
                    end
                    3'b101: begin
                        am = ZPGX;
                        if (aaa == 3'b100) mn = STY;
                        else if (aaa == 3'b101) mn = LDY;
                    end
                    3'b110: begin
                        case (aaa)
                            3'b000:  mn = CLC;
                            3'b001:  mn = SEC;
                            3'b010:  mn = CLI;
                            3'b011:  mn = SEI;
                            3'b100:  mn = TYA;
                            3'b101:  mn = CLV;
                            3'b110:  mn = CLD;
                            default: mn = SED;
                        endcase
                    end
                    default: begin
                        am = ABSX;
                        if (aaa == 3'b101) mn = LDY;   // BC
                    end
                endcase
            end
            2'b01: begin
                // alu group, regular in both fields
                case (bbb)
                    3'b000:  am = XIND;
                    3'b001:  am = ZPG;
                    3'b010:  am = IMM;
                    3'b011:  am = ABS;
                    3'b100:  am = INDY;
                    3'b101:  am = ZPGX;
                    3'b110:  am = ABSY;
                    default: am = ABSX;
                endcase
                case (aaa)
                    3'b000:  mn = ORA;
                    3'b001:  mn = AND;
                    3'b010:  mn = EOR;
                    3'b011:  mn = ADC;
                    3'b100:  mn = STA;
                    3'b101:  mn = LDA;
                    3'b110:  mn = CMP;
                    default: mn = SBC;
                endcase
                if (aaa == 3'b100 && bbb == 3'b010) mn = NONE;  // no sta #imm
            end
            2'b10: begin
                case (bbb)
                    3'b000: begin
                        if (aaa == 3'b101) begin
                            mn = LDX;
                            am = IMM;
                        end
                    end
                    3'b001: begin
                        mn = rmwMn;
                        am = ZPG;
                    end
                    3'b010: begin
                        case (aaa)
                            3'b000:  mn = ASLA;
                            3'b001:  mn = ROLA;
                            3'b010:  mn = LSRA;
                            3'b011:  mn = RORA;
                            3'b100:  mn = TXA;
                            3'b101:  mn = TAX;
                            3'b110:  mn = DEX;
                            default: mn = NOP;
                        endcase
                        am = aaa[2] ? IMPL : ACC;
                    end
                    3'b011: begin
                        mn = rmwMn;
                        am = ABS;
                    end
                    3'b101: begin
                        mn = rmwMn;
                        am = (aaa[2:1] == 2'b10) ? ZPGY : ZPGX;    // stx/ldx index by y
                    end
                    3'b110: begin
                        if (aaa == 3'b100) mn = TXS;
                        else if (aaa == 3'b101) mn = TSX;
                    end
                    3'b111: begin
                        if (aaa != 3'b100) mn = rmwMn;  // 9E is empty
                        am = (aaa == 3'b101) ? ABSY : ABSX;
                    end
                    default: mn = NONE;
                endcase
            end
            default: mn = NONE;     // cc=11 holds no official opcodes
        endcase
        if (mn == NONE) am = IMPL;
    end

    always_comb begin
        case (am)
            ACC, IMPL:              len = 2'd0;
            ABS, ABSX, ABSY, IND:   len = 2'd2;
            default:                len = 2'd1;
        endcase
    end

    assign info = '{mnemonic: mn, mode: am, count: len, illegal: (mn == NONE)};

endmodule

`default_nettype wire

/* hw/operandResolver.sv */
`default_nettype none
`timescale 1ns/100ps

`include "decoder_cfg.svh"

module operandResolver import cpu6502Pkg::*, decodePkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     rawValid,
    input  rawInstrT raw,
    output logic     instrValid,
    output instrT    instr
);

    logic [15:0] operand;
    logic [15:0] offset;
    logic [15:0] target;

    always_comb begin
        case (raw.info.count)
            2'd2:    operand = {raw.opHigh, raw.opLow};
            2'd1:    operand = {{(16 - `BYTE_W){1'b0}}, raw.opLow};
            default: operand = '0;
        endcase
    end

    // displacement counts from the byte after the branch
    assign offset = {{(16 - `BYTE_W){raw.opLow[`BYTE_W-1]}}, raw.opLow};
    assign target = (raw.info.mode == REL) ? raw.pc + 16'd2 + offset : '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrValid <= 1'b0;
        end else begin
            instrValid <= rawValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rawValid) begin
            instr.pc      <= raw.pc;
            instr.opcode  <= raw.opcode;
            instr.info    <= raw.info;
            instr.operand <= operand;
            instr.target  <= target;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN)
        instrValid && (instr.target != '0) |-> $past(raw.info.mode) == REL);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the decode front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module decodeTb -f src.f -Mdir obj_dir -o decodeSim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/decodeSim > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi

if [ $SIM_STATUS -ne 0 ]; then
    echo "simulation exited with status $SIM_STATUS"
    exit 1
fi

exit 0

/* src.f */
+incdir+hw
+incdir+tb
hw/cpu6502Pkg.sv
hw/decodePkg.sv
hw/opcodeDecoder.sv
hw/instrAssembler.sv
hw/operandResolver.sv
hw/decodeTop.sv
tb/decodeTb.sv

/* tb/opcodeModel.svh */
`ifndef OPCODE_MODEL_SVH
`define OPCODE_MODEL_SVH

// regular columns of the official map, indexed by the top three opcode bits
localparam mnemonicT ALU_ROW    [8] = '{ORA, AND, EOR, ADC, STA, LDA, CMP, SBC};
localparam mnemonicT RMW_ROW    [8] = '{ASL, ROL, LSR, ROR, STX, LDX, DEC, INC};
localparam mnemonicT ACC_ROW    [8] = '{ASLA, ROLA, LSRA, RORA, TXA, TAX, DEX, NOP};
localparam mnemonicT BRANCH_ROW [8] = '{BPL, BMI, BVC, BVS, BCC, BCS, BNE, BEQ};
localparam mnemonicT FLAG_ROW   [8] = '{CLC, SEC, CLI, SEI, TYA, CLV, CLD, SED};
localparam mnemonicT STACK_ROW  [8] = '{PHP, PLP, PHA, PLA, DEY, TAY, INY, INX};

// stream model state
logic [15:0] mPc;
logic [15:0] mOpPc;
logic [7:0]  mOp;
logic [7:0]  mLo;
logic [7:0]  mHi;
opInfoT      mInfo;
int          mIdx;          // 0 waits for an opcode
instrT       expQ[$];
int          dueQ[$];       // cycle in which each record must show up

function automatic mnemonicT refMnemonic(input logic [7:0] op);
    mnemonicT m;
    case (op[4:0])
        5'h10: m = BRANCH_ROW[op[7:5]];
        5'h18: m = FLAG_ROW[op[7:5]];
        5'h08: m = STACK_ROW[op[7:5]];
        5'h0A: m = ACC_ROW[op[7:5]];
        5'h06, 5'h0E, 5'h16, 5'h1E: m = RMW_ROW[op[7:5]];
        5'h01, 5'h05, 5'h09, 5'h0D, 5'h11, 5'h15, 5'h19, 5'h1D: m = ALU_ROW[op[7:5]];
        default: m = NONE;
    endcase
    // holes in the columns and the scattered singles
    case (op)
        8'h89, 8'h9E: m = NONE;
        8'h00: m = BRK;
        8'h20: m = JSR;
        8'h40: m = RTI;
        8'h60: m = RTS;
        8'h24, 8'h2C: m = BIT;
        8'h4C, 8'h6C: m = JMP;
        8'h84, 8'h8C, 8'h94: m = STY;
        8'hA0, 8'hA4, 8'hAC, 8'hB4, 8'hBC: m = LDY;
        8'hC0, 8'hC4, 8'hCC: m = CPY;
        8'hE0, 8'hE4, 8'hEC: m = CPX;
        8'hA2: m = LDX;
        8'h9A: m = TXS;
        8'hBA: m = TSX;
        default: ;
    endcase
    return m;
endfunction

// mode follows the low five bits, with a few named exceptions
function automatic addrModeT refMode(input logic [7:0] op);
    addrModeT a;
    case (op[4:0])
        5'h01: a = XIND;
        5'h02, 5'h09: a = IMM;
        5'h04, 5'h05, 5'h06: a = ZPG;
        5'h00: a = (op == 8'h20) ? ABS : (op[7] ? IMM : IMPL);
        5'h0C, 5'h0D, 5'h0E: a = (op == 8'h6C) ? IND : ABS;
        5'h10: a = REL;
        5'h11: a = INDY;
        5'h14, 5'h15: a = ZPGX;
        5'h16: a = (op[7:6] == 2'b10) ? ZPGY : ZPGX;   // stx, ldx
        5'h19: a = ABSY;
        5'h1C, 5'h1D: a = ABSX;
        5'h1E: a = (op == 8'hBE) ? ABSY : ABSX;
        5'h0A: a = op[7] ? IMPL : ACC;
        default: a = IMPL;
    endcase
    return a;
endfunction

function automatic opInfoT refInfo(input logic [7:0] op);
    opInfoT r;
    r.mnemonic = refMnemonic(op);
    r.illegal  = (r.mnemonic == NONE);
    r.mode     = r.illegal ? IMPL : refMode(op);
    case (r.mode)
        ACC, IMPL:            r.count = 2'd0;
        ABS, ABSX, ABSY, IND: r.count = 2'd2;
        default:              r.count = 2'd1;
    endcase
    return r;
endfunction

function automatic instrT refResolve(input logic [15:0] pc, input logic [7:0] op,
                                     input opInfoT info, input logic [7:0] lo,
                                     input logic [7:0] hi);
    instrT r;
    int    tgt;
    r.pc     = pc;
    r.opcode = op;
    r.info   = info;
    if (info.count == 2'd2) r.operand = {hi, lo};
    else if (info.count == 2'd1) r.operand = {8'h00, lo};
    else r.operand = 16'h0000;
    tgt      = int'(pc) + 2 + int'($signed(lo));   // wraps when truncated
    r.target = (info.mode == REL) ? tgt[15:0] : 16'h0000;
    return r;
endfunction

task automatic modelReset();
    mPc  = `RESET_PC;
    mIdx = 0;
    expQ.delete();
    dueQ.delete();
endtask

task automatic modelStep(input logic load, input logic [15:0] loadVal, input logic valid,
                         input logic [7:0] data, input int due);
    if (load) begin
        mPc  = loadVal;
        mIdx = 0;       // half-built record is gone
    end
    if (valid) begin
        if (mIdx == 0) begin
            mOpPc = mPc;
            mOp   = data;
            mInfo = refInfo(data);
            mLo   = 8'h00;
            mHi   = 8'h00;
        end else if (mIdx == 1) begin
            mLo = data;
        end else begin
            mHi = data;
        end
        mPc = mPc + 16'd1;
        if (mIdx == int'(mInfo.count)) begin
            expQ.push_back(refResolve(mOpPc, mOp, mInfo, mLo, mHi));
            dueQ.push_back(due);
            mIdx = 0;
        end else begin
            mIdx = mIdx + 1;
        end
    end
endtask

`endif

/* tb/decodeTb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "decoder_cfg.svh"

module decodeTb import cpu6502Pkg::*, decodePkg::*; ();

    localparam int NUM_BYTES = 4000;
    localparam int LIMIT     = NUM_BYTES * 2 + 200;     // at most two cycles per byte

    logic               clk;
    logic               arstN;
    logic               byteValid;
    logic [`BYTE_W-1:0] byteData;
    logic               pcLoad;
    logic [15:0]        pcLoadValue;
    logic               instrValid;
    instrT              instr;

    logic [15:0] lfsr;
    int          cycles = 0;

    `include "opcodeModel.svh"

    decodeTop u_dut (
        .clk         (clk),
        .arstN       (arstN),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .pcLoad      (pcLoad),
        .pcLoadValue (pcLoadValue),
        .instrValid  (instrValid),
        .instr       (instr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
    endtask

    task automatic checkInfo(input opInfoT got, input opInfoT exp, input logic [15:0] pc);
        if (got !== exp)
            abortRun($sformatf("Mismatch at %0t: info at %h got %s %s %0d %b, expected %s %s %0d %b",
                $time, pc, got.mnemonic.name(), got.mode.name(), got.count, got.illegal,
                exp.mnemonic.name(), exp.mode.name(), exp.count, exp.illegal));
    endtask

    task automatic checkInstr(input instrT got, input instrT exp);
        checkInfo(got.info, exp.info, exp.pc);
        if (got.pc !== exp.pc || got.opcode !== exp.opcode || got.operand !== exp.operand
                || got.target !== exp.target)
            abortRun($sformatf("Mismatch at %0t: got pc %h op %h opnd %h tgt %h, expected %h %h %h %h",
                $time, got.pc, got.opcode, got.operand, got.target,
                exp.pc, exp.opcode, exp.operand, exp.target));
    endtask

    task automatic watchOutputs(input int cyc);
        instrT exp;
        int    due;
        if (dueQ.size() != 0 && dueQ[0] < cyc) begin
            abortRun($sformatf("instruction at %h was never emitted", expQ[0].pc));
        end else if (instrValid) begin
            if (expQ.size() == 0) begin
                abortRun("instrValid pulsed with no instruction pending");
            end else begin
                exp = expQ.pop_front();
                due = dueQ.pop_front();
                if (due != cyc)
                    abortRun($sformatf("Mismatch at %0t: instrValid in cycle %0d, expected %0d",
                        $time, cyc, due));
                else
                    checkInstr(instr, exp);
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT)
            abortRun($sformatf("timeout, run did not finish within %0d cycles", LIMIT));
    end

    initial begin
        logic [15:0] r;
        logic        strobe;
        logic        gapPrev;
        int          sent;
        int          cyc;
        arstN       = 1'b0;
        byteValid   = 1'b0;
        byteData    = '0;
        pcLoad      = 1'b0;
        pcLoadValue = '0;
        lfsr        = 16'd54011;
        gapPrev     = 1'b0;
        sent        = 0;
        cyc         = 0;
        modelReset();
        repeat (3) begin
            @(negedge clk);
            if (instrValid) abortRun("instrValid high while in reset");
        end
        arstN = 1'b1;
        while (sent < NUM_BYTES || expQ.size() != 0) begin
            @(negedge clk);
            cyc = cyc + 1;
            watchOutputs(cyc);
            byteValid = 1'b0;
            pcLoad    = 1'b0;
            if (sent < NUM_BYTES) begin
                takeBits(6, r);
                if (r[5:0] == 6'd0) begin  // roughly one cycle in 64
                    takeBits(16, r);
                    pcLoad      = 1'b1;
                    pcLoadValue = r;
                end
                takeBits(1, r);
                strobe  = r[0] || gapPrev;  // gaps never back to back
                gapPrev = !strobe;
                if (strobe) begin
                    takeBits(8, r);
                    byteValid = 1'b1;
                    byteData  = r[7:0];
                    sent      = sent + 1;
                end
                modelStep(pcLoad, pcLoadValue, byteValid, byteData, cyc + 2);
            end
        end
        repeat (4) begin       // nothing stray after the last record
            @(negedge clk);
            cyc = cyc + 1;
            watchOutputs(cyc);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
